// ==== src/video_pkg.sv ====
// video pixel back end types
package video_pkg;

	// render mode, as carried in the pixel controls
	typedef enum logic [1:0] {
		rm_zx = 2'd0,
		rm_hc = 2'd1,
		rm_xc = 2'd2,
		rm_tx = 2'd3
	} render_mode_t;

	// zx view with the bitmap in the low half and attributes in the high half
	typedef struct packed {
		logic [15:0] attr;
		logic [15:0] gfx;
	} zx_word_t;

	// one video memory word seen as zx halves or as four bytes
	typedef union packed {
		zx_word_t        zx;
		logic [3:0][7:0] bytes;
	} video_word_u;

	// per-pixel controls from the raster logic
	typedef struct packed {
		// inside the active area
		logic         hvpix;
		// graphics off so only the border shows
		logic         nogfx;
		// flash phase for zx attributes
		logic         flash;
		// two 4-bit pixels per plex byte
		logic         hires;
		// hi-res nibble latch strobe
		logic         c1;
		// pixel position within the word
		logic [3:0]   psel;
		render_mode_t mode;
	} pix_ctl_t;

	// decode to execute
	typedef struct packed {
		pix_ctl_t    ctl;
		logic [3:0]  border;
		video_word_u word;
	} stage_t;

	// execute to result
	typedef struct packed {
		pix_ctl_t   ctl;
		logic [3:0] border;
		// pixel for the selected mode before the border mux
		logic [7:0] pixel;
	} pix_out_t;

endpackage

// ==== src/video_fetch.sv ====
// video decode stage
`timescale 1ns/1ns

module video_fetch (
	input  logic               clk,
	input  logic               rst_n,
	input  video_pkg::pix_ctl_t ctl_in,
	input  logic [3:0]         border_in,
	input  logic [31:0]        data,
	input  logic               data_load,
	output video_pkg::stage_t  stage
);

	import video_pkg::*;

	// held pixel controls and border colour
	pix_ctl_t    ctl_q;
	logic [3:0]  border_q;

	// held video word, shared by several pixels
	video_word_u word_q;
	video_word_u word_d;

	// controls follow the raster every clock
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctl_q    <= '0;
			border_q <= '0;
		end else begin
			ctl_q    <= ctl_in;
			border_q <= border_in;
		end
	end

	// new word only on the load strobe
	always_comb begin
		if (data_load) begin
			word_d = data;
		end else begin
			word_d = word_q;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			word_q <= '0;
		end else begin
			word_q <= word_d;
		end
	end

	// registered stage towards the renderer
	always_comb begin
		stage.ctl    = ctl_q;
		stage.border = border_q;
		stage.word   = word_q;
	end

endmodule

// ==== src/video_render.sv ====
// video execute stage
`timescale 1ns/1ns

module video_render #(
	parameter logic [3:0] zx_pal_page = 4'hF,
	parameter logic [3:0] hc_pal_page = 4'hE
) (
	input  video_pkg::stage_t   stage,
	output video_pkg::pix_out_t pix
);

	import video_pkg::*;

	video_word_u w;
	logic [3:0]  p;

	// zx and text share the dot and attribute lookup
	logic        zx_dot;
	logic [7:0]  zx_attr;
	logic        zx_ink;
	logic [7:0]  zx_pix;
	logic [7:0]  tx_pix;

	// 16-colour nibbles in display order
	logic [3:0]  hc_nib [8];
	logic [7:0]  hc_pix;

	logic [7:0]  xc_pix;
	logic [7:0]  mode_pix;

	assign w = stage.word;
	assign p = stage.ctl.psel;

	// bitmap bit 7 is the leftmost dot of each byte
	assign zx_dot = w.zx.gfx[{p[3], ~p[2:0]}];

	// one attribute byte per bitmap byte
	always_comb begin
		if (p[3]) begin
			zx_attr = w.zx.attr[15:8];
		end else begin
			zx_attr = w.zx.attr[7:0];
		end
	end

	// attr bit 7 swaps ink and paper in the flash phase
	assign zx_ink = zx_dot ^ (stage.ctl.flash & zx_attr[7]);

	always_comb begin
		if (zx_ink) begin
			zx_pix = {zx_pal_page, zx_attr[6], zx_attr[2:0]};
		end else begin
			zx_pix = {zx_pal_page, zx_attr[6], zx_attr[5:3]};
		end
	end

	// text attribute is a foreground and background nibble pair
	always_comb begin
		if (zx_dot) begin
			tx_pix = {zx_pal_page, zx_attr[3:0]};
		end else begin
			tx_pix = {zx_pal_page, zx_attr[7:4]};
		end
	end

	// high nibble first within each byte
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			hc_nib[2*i]     = w.bytes[i][7:4];
			hc_nib[2*i + 1] = w.bytes[i][3:0];
		end
	end

	assign hc_pix = {hc_pal_page, hc_nib[p[2:0]]};

	// in 256-colour mode the byte is the palette index
	assign xc_pix = w.bytes[p[1:0]];

	always_comb begin
		case (stage.ctl.mode)
			rm_zx:   mode_pix = zx_pix;
			rm_hc:   mode_pix = hc_pix;
			rm_xc:   mode_pix = xc_pix;
			rm_tx:   mode_pix = tx_pix;
			default: mode_pix = zx_pix;
		endcase
	end

	// controls and border ride along with the pixel
	always_comb begin
		pix.ctl    = stage.ctl;
		pix.border = stage.border;
		pix.pixel  = mode_pix;
	end

endmodule

// ==== src/video_plex.sv ====
// video result stage
`timescale 1ns/1ns

module video_plex #(
	parameter logic [3:0] border_page = 4'hF
) (
	input  logic                clk,
	input  logic                rst_n,
	input  video_pkg::pix_out_t pix,
	output logic [7:0]          vplex_out
);

	// picture or border for this pixel
	logic       show_pix;
	logic [7:0] border_pix;
	logic [7:0] vplex;

	// first pixel of a hi-res pair
	logic [3:0] held_nib;
	logic [7:0] vplex_d;

	assign show_pix   = pix.ctl.hvpix & ~pix.ctl.nogfx;
	assign border_pix = {border_page, pix.border};

	always_comb begin
		if (show_pix) begin
			vplex = pix.pixel;
		end else begin
			vplex = border_pix;
		end
	end

	// hi-res packs two 4-bit pixels with the older one in the high nibble
	always_comb begin
		if (pix.ctl.hires) begin
			vplex_d = {held_nib, vplex[3:0]};
		end else begin
			vplex_d = vplex;
		end
	end

	// latch on c1 while the output at this edge still sees the old value
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held_nib <= '0;
		end else if (pix.ctl.c1) begin
			held_nib <= vplex[3:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vplex_out <= '0;
		end else begin
			vplex_out <= vplex_d;
		end
	end

endmodule

// ==== src/video_top.sv ====
// video pixel back end top level
`timescale 1ns/1ns

module video_top #(
	// palette pages for the upper nibble of each pixel kind
	parameter logic [3:0] zx_pal_page = 4'hF,
	parameter logic [3:0] hc_pal_page = 4'hE,
	parameter logic [3:0] border_page = 4'hF
) (
	input  logic                clk,
	input  logic                rst_n,
	input  video_pkg::pix_ctl_t ctl_in,
	input  logic [3:0]          border_in,
	input  logic [31:0]         data,
	input  logic                data_load,
	output logic [7:0]          vplex_out
);

	import video_pkg::*;

	// decode to execute
	stage_t   stage;

	// execute to result
	pix_out_t pix;

	video_fetch fetch_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl_in    (ctl_in),
		.border_in (border_in),
		.data      (data),
		.data_load (data_load),
		.stage     (stage)
	);

	video_render #(
		.zx_pal_page (zx_pal_page),
		.hc_pal_page (hc_pal_page)
	) render_i (
		.stage (stage),
		.pix   (pix)
	);

	video_plex #(
		.border_page (border_page)
	) plex_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix       (pix),
		.vplex_out (vplex_out)
	);

endmodule

// ==== test/video_top_chk.sv ====
// result stage assertions
`timescale 1ns/1ns

module video_top_chk (
	input logic                clk,
	input logic                rst_n,
	input video_pkg::pix_out_t pix,
	input logic [3:0]          held_nib,
	input logic [7:0]          vplex_out,
	input logic [3:0]          page
);

	// number of failed assertions
	int assert_fails = 0;

	// output register cleared by a reset edge
	reset_clears: assert property (@(posedge clk) !rst_n |=> vplex_out == 8'h00)
		else begin
			$error("vplex_out not cleared after reset");
			assert_fails++;
		end

	// hi-res latch only moves on c1
	held_stable: assert property (@(posedge clk) disable iff (!rst_n)
		!pix.ctl.c1 |=> $stable(held_nib))
		else begin
			$error("held nibble changed while c1 was low");
			assert_fails++;
		end

	// border page on top outside the active area
	border_page_shown: assert property (@(posedge clk) disable iff (!rst_n)
		(!pix.ctl.hires && !pix.ctl.hvpix) |=> vplex_out[7:4] == page)
		else begin
			$error("upper nibble is not the border page outside the active area");
			assert_fails++;
		end

endmodule

bind video_plex video_top_chk chk_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.pix       (pix),
	.held_nib  (held_nib),
	.vplex_out (vplex_out),
	.page      (border_page)
);

// ==== test/video_top_tb.sv ====
// video back end testbench
`timescale 1ns/1ns

module video_top_tb;

	import video_pkg::*;

	// non-default pages so each one is visible in the output
	localparam logic [3:0] zx_page  = 4'hA;
	localparam logic [3:0] hc_page  = 4'h5;
	localparam logic [3:0] bdr_page = 4'hC;

	typedef struct packed {
		render_mode_t mode;
		logic [3:0]   psel;
		logic         hvpix;
		logic         nogfx;
		logic         flash;
		logic         hires;
		logic         c1;
		logic [3:0]   border;
		logic         load;
		logic [31:0]  data;
		logic [7:0]   expected;
	} entry_t;

	logic        clk = 1'b0;
	logic        rst_n;
	pix_ctl_t    ctl_in;
	logic [3:0]  border_in;
	logic [31:0] data;
	logic        data_load;
	logic [7:0]  vplex_out;

	entry_t      stim[$];
	int          exp_q[$];
	bit          stim_ready = 1'b0;
	int          checks;
	int          errors;

	// reference model state
	logic [15:0] lfsr_state;
	logic [31:0] model_word;
	logic [3:0]  model_held;

	video_top #(
		.zx_pal_page (zx_page),
		.hc_pal_page (hc_page),
		.border_page (bdr_page)
	) dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl_in    (ctl_in),
		.border_in (border_in),
		.data      (data),
		.data_load (data_load),
		.vplex_out (vplex_out)
	);

	always #5 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[15]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic logic [7:0] model_pixel(input render_mode_t mode, input logic [3:0] p,
		input logic flash, input logic [31:0] w);
		logic [15:0] g;
		logic [15:0] a;
		logic [3:0]  bi;
		logic        dot;
		logic [7:0]  at;
		logic [2:0]  colour;
		logic [4:0]  lo;
		logic [7:0]  result;
		g  = w[15:0];
		a  = w[31:16];
		// leftmost dot is the top bit of the bitmap byte
		bi  = {p[3], 3'd7 - p[2:0]};
		dot = g[bi];
		at  = p[3] ? a[15:8] : a[7:0];
		case (mode)
			rm_zx: begin
				if (dot ^ (flash & at[7]))
					colour = at[2:0];
				else
					colour = at[5:3];
				result = {zx_page, at[6], colour};
			end
			rm_tx: result = {zx_page, dot ? at[3:0] : at[7:4]};
			rm_hc: begin
				// even index takes the high nibble
				lo     = {p[2:1], ~p[0], 2'b00};
				result = {hc_page, w[lo +: 4]};
			end
			default: begin
				lo     = {p[1:0], 3'b000};
				result = w[lo +: 8];
			end
		endcase
		return result;
	endfunction

	// one table row with its expected output from the model
	task automatic add_entry(input render_mode_t mode, input logic [3:0] psel,
		input logic hvpix, input logic nogfx, input logic flash, input logic hires,
		input logic c1, input logic load);
		entry_t      e;
		logic [31:0] r;
		logic [7:0]  plex;
		e.mode  = mode;
		e.psel  = psel;
		e.hvpix = hvpix;
		e.nogfx = nogfx;
		e.flash = flash;
		e.hires = hires;
		e.c1    = c1;
		e.load  = load;
		draw_bits(32, r);
		e.data = r;
		draw_bits(4, r);
		e.border = r[3:0];
		if (load)
			model_word = e.data;
		if (hvpix && !nogfx)
			plex = model_pixel(mode, psel, flash, model_word);
		else
			plex = {bdr_page, e.border};
		if (hires)
			e.expected = {model_held, plex[3:0]};
		else
			e.expected = plex;
		// latch after the output so this pixel still pairs with the old nibble
		if (c1)
			model_held = plex[3:0];
		stim.push_back(e);
	endtask

	task automatic build_stim();
		int pass;
		int i;
		int m;
		for (pass = 0; pass < 4; pass++)
			for (i = 0; i < 16; i++)
				add_entry(rm_zx, i[3:0], 1'b1, 1'b0, pass[0], 1'b0, 1'b0, i == 0);
		for (pass = 0; pass < 2; pass++)
			for (i = 0; i < 16; i++)
				add_entry(rm_tx, i[3:0], 1'b1, 1'b0, pass[0], 1'b0, 1'b0, i == 0);
		for (pass = 0; pass < 3; pass++)
			for (i = 0; i < 8; i++)
				add_entry(rm_hc, i[3:0], 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, i == 0);
		for (pass = 0; pass < 3; pass++)
			for (i = 0; i < 4; i++)
				add_entry(rm_xc, i[3:0], 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, i == 0);
		// border when blanked or with graphics off or both
		for (m = 0; m < 4; m++)
			for (i = 0; i < 3; i++)
				add_entry(render_mode_t'(m[1:0]), i[3:0], i == 2, i != 0, 1'b1,
					1'b0, 1'b0, 1'b1);
		// one load and then reuse of the held word
		for (i = 0; i < 9; i++)
			add_entry(rm_xc, {2'b00, i[1:0]}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, i == 0);
		// hi-res pairs with the latch on even pixels
		for (i = 0; i < 16; i++)
			add_entry(rm_hc, {1'b0, i[2:0]}, 1'b1, 1'b0, 1'b0, 1'b1, !i[0],
				i == 0 || i == 8);
		for (i = 0; i < 8; i++)
			add_entry(rm_xc, {2'b00, i[1:0]}, 1'b1, 1'b0, 1'b0, 1'b1, !i[0], i == 0);
		for (i = 0; i < 4; i++)
			add_entry(rm_tx, i[3:0], 1'b0, 1'b0, 1'b0, 1'b1, !i[0], 1'b0);
		for (i = 0; i < 4; i++)
			add_entry(rm_zx, i[3:0], 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, i == 0);
	endtask

	task automatic apply_entry(input entry_t e);
		ctl_in.hvpix = e.hvpix;
		ctl_in.nogfx = e.nogfx;
		ctl_in.flash = e.flash;
		ctl_in.hires = e.hires;
		ctl_in.c1    = e.c1;
		ctl_in.psel  = e.psel;
		ctl_in.mode  = e.mode;
		border_in    = e.border;
		data         = e.data;
		data_load    = e.load;
	endtask

	// compare the oldest pixel in flight
	task automatic check_output();
		int idx;
		idx = exp_q.pop_front();
		checks++;
		assert (vplex_out === stim[idx].expected)
		else begin
			$display("mismatch at %0t ns: entry %0d expected %h got %h",
				$time, idx, stim[idx].expected, vplex_out);
			errors++;
		end
	endtask

	initial begin
		longint limit_ns;
		wait (stim_ready);
		limit_ns = (longint'(stim.size()) + 8 + 20) * 10;
		#(limit_ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int i;
		rst_n      = 1'b0;
		ctl_in     = '0;
		border_in  = '0;
		data       = '0;
		data_load  = 1'b0;
		checks     = 0;
		errors     = 0;
		lfsr_state = 16'd59;
		model_word = '0;
		model_held = '0;
		build_stim();
		stim_ready = 1'b1;

		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		for (i = 0; i < stim.size(); i++) begin
			@(negedge clk);
			if (exp_q.size() == 2)
				check_output();
			apply_entry(stim[i]);
			exp_q.push_back(i);
		end

		// drain the two pixels still in the pipeline
		repeat (2) begin
			@(negedge clk);
			check_output();
			ctl_in    = '0;
			data_load = 1'b0;
		end

		$display("checks: %0d, mismatches: %0d, assertion failures: %0d",
			checks, errors, dut_i.plex_i.chk_i.assert_fails);
		if (errors == 0 && dut_i.plex_i.chk_i.assert_fails == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== video_top.f ====
src/video_pkg.sv
src/video_fetch.sv
src/video_render.sv
src/video_plex.sv
src/video_top.sv
test/video_top_chk.sv
test/video_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the video back end testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module video_top_tb \
	-f video_top.f -o video_top_sim; then
	echo "verilator build failed"
	exit 1
fi

# assertion errors are counted by the testbench, so keep running past them
sim_out=$(./obj_dir/video_top_sim +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q 'All tests passed!'; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1
